// File: flist.f
+incdir+logic
logic/ctrlPkg.sv
logic/instrDecoder.sv
logic/stateSequencer.sv
logic/controlWordRom.sv
logic/mipsControl.sv
tb/mipsControlTb.sv

// File: tb/mipsControlTb.sv
`include "ctrl_consts.svh"

module mipsControlTb;

    logic               clk;
    logic               reset;
    logic [5:0]         opcode;
    logic [5:0]         funct;
    logic               overflow;
    ctrlPkg::ctrlWord_t ctrl;

    int errors;
    bit timedOut;
    int lenTable [0:11]; // irWrite-to-irWrite cycles per class

    mipsControl mipsControl_inst (
        .clk      (clk),
        .reset    (reset),
        .opcode   (opcode),
        .funct    (funct),
        .overflow (overflow),
        .ctrl     (ctrl)
    );

    always #5 clk = ~clk;

    task automatic checkEq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("timeout: %s did not arrive within 100 cycles", what);
        errors++;
        timedOut = 1'b1;
    endtask

    task automatic fillLengths();
        lenTable[int'(ctrlPkg::clsAdd)]   = 6;
        lenTable[int'(ctrlPkg::clsAddi)]  = 6;
        lenTable[int'(ctrlPkg::clsAddiu)] = 6;
        lenTable[int'(ctrlPkg::clsLw)]    = 9;
        lenTable[int'(ctrlPkg::clsSw)]    = 6;
        lenTable[int'(ctrlPkg::clsBeq)]   = 5;
        lenTable[int'(ctrlPkg::clsBne)]   = 5;
        lenTable[int'(ctrlPkg::clsJ)]     = 5;
        lenTable[int'(ctrlPkg::clsJal)]   = 6;
        lenTable[int'(ctrlPkg::clsJr)]    = 5;
        lenTable[int'(ctrlPkg::clsMult)]  = 4 + 1 + `MULT_CYCLES + 1;
        lenTable[int'(ctrlPkg::clsBad)]   = 8;
    endtask

    // builds the opcode and funct of a class
    function automatic void encode(input ctrlPkg::instrClass_t cls,
                                   output logic [5:0] op, output logic [5:0] fn);
        fn = 6'($urandom); // noise outside R-type
        op = `OP_RTYPE;
        case (cls)
            ctrlPkg::clsAdd:   fn = `FN_ADD;
            ctrlPkg::clsJr:    fn = `FN_JR;
            ctrlPkg::clsMult:  fn = `FN_MULT;
            ctrlPkg::clsAddi:  op = `OP_ADDI;
            ctrlPkg::clsAddiu: op = `OP_ADDIU;
            ctrlPkg::clsLw:    op = `OP_LW;
            ctrlPkg::clsSw:    op = `OP_SW;
            ctrlPkg::clsBeq:   op = `OP_BEQ;
            ctrlPkg::clsBne:   op = `OP_BNE;
            ctrlPkg::clsJ:     op = `OP_J;
            ctrlPkg::clsJal:   op = `OP_JAL;
            default:           op = 6'h3f; // no such opcode
        endcase
    endfunction

    task automatic resetTest();
        ctrlPkg::ctrlWord_t spWord;
        int waited;
        spWord = '0;
        spWord.reg_.regWrite = 1'b1;
        spWord.reg_.regDst   = `DST_SP;
        spWord.reg_.memToReg = `WB_SPINIT;
        reset = 1'b1;
        repeat (10) begin
            @(negedge clk);
            checkEq("ctrl", ctrl, spWord);
        end
        reset = 1'b0;
        checkEq("ctrl", ctrl, spWord); // still stInit until the next edge
        waited = 0;
        while (!ctrl.mem.irWrite && !timedOut) begin
            @(negedge clk);
            waited++;
            if (!ctrl.mem.irWrite && waited >= 100) begin
                reportTimeout("first irWrite");
            end
        end
        if (!timedOut) begin
            checkEq("first irWrite delay", waited, 3);
        end
    endtask

    // starts and ends on a falling edge inside an irWrite cycle
    task automatic runInstr(input ctrlPkg::instrClass_t cls, input logic ovf);
        logic [5:0] op;
        logic [5:0] fn;
        logic [1:0] expDst = '0;
        logic [3:0] expWb = '0;
        logic [2:0] vector;
        bit trap;
        bit done = 1'b0;
        int expLen;
        int expWrites = 0;
        int cycles = 0;
        int regWrites = 0;
        int memWrites = 0;
        int condWrites = 0;
        int epcWrites = 0;
        int excJumps = 0;
        int multInits = 0;
        int hiLoWrites = 0;
        int epcCycle = 0;
        int excCycle = 0;
        int multCycle = 0;
        int hiLoCycle = 0;
        if (timedOut) return;
        trap = (cls == ctrlPkg::clsBad) ||
               (ovf && (cls == ctrlPkg::clsAdd || cls == ctrlPkg::clsAddi));
        expLen = (trap && cls != ctrlPkg::clsBad) ? 9 : lenTable[int'(cls)];
        vector = (cls == ctrlPkg::clsBad) ? `IORD_BADOP : `IORD_OVF;
        case (cls)
            ctrlPkg::clsAdd: begin
                expDst = `DST_RD;
                expWb = `WB_ALUOUT;
                expWrites = 1;
            end
            ctrlPkg::clsAddi, ctrlPkg::clsAddiu: begin
                expDst = `DST_RT;
                expWb = `WB_ALUOUT;
                expWrites = 1;
            end
            ctrlPkg::clsLw: begin
                expDst = `DST_RT;
                expWb = `WB_MDR;
                expWrites = 1;
            end
            ctrlPkg::clsJal: begin
                expDst = `DST_RA;
                expWb = `WB_PC;
                expWrites = 1;
            end
            default: expWrites = 0;
        endcase
        if (trap) expWrites = 0;
        encode(cls, op, fn);
        opcode = op; // instruction register now holds the new word
        funct = fn;
        overflow = ovf;
        while (!done && !timedOut) begin
            @(negedge clk);
            cycles++;
            if (ctrl.reg_.regWrite) begin
                regWrites++;
                checkEq("ctrl.reg_.regDst", ctrl.reg_.regDst, expDst);
                checkEq("ctrl.reg_.memToReg", ctrl.reg_.memToReg, expWb);
            end
            if (ctrl.mem.memWrite) begin
                memWrites++;
                checkEq("ctrl.mem.iorD", ctrl.mem.iorD, `IORD_ALUOUT);
            end
            if (ctrl.pc.pcWriteCond) begin
                condWrites++;
                checkEq("ctrl.pc.eqOrNe", ctrl.pc.eqOrNe,
                        (cls == ctrlPkg::clsBeq) ? 2'b10 : 2'b01);
            end
            if (ctrl.mult.epcWrite) begin
                epcWrites++;
                epcCycle = cycles;
                checkEq("ctrl.mem.iorD", ctrl.mem.iorD, vector);
            end
            if (ctrl.pc.pcWrite && ctrl.pc.pcSrc == `PCSRC_EXC) begin
                excJumps++;
                excCycle = cycles;
            end
            if (ctrl.mult.multInit) begin
                if (multInits == 0) multCycle = cycles;
                multInits++;
            end
            if (ctrl.mult.hiLoWrite) begin
                if (hiLoWrites == 0) hiLoCycle = cycles;
                hiLoWrites++;
            end
            if (ctrl.mem.irWrite) begin
                done = 1'b1;
            end else if (cycles >= 100) begin
                reportTimeout("next irWrite");
            end
        end
        if (timedOut) return;
        checkEq("instruction length", cycles, expLen);
        checkEq("regWrite cycles", regWrites, expWrites);
        checkEq("memWrite cycles", memWrites, (cls == ctrlPkg::clsSw) ? 1 : 0);
        checkEq("pcWriteCond cycles", condWrites,
                (cls == ctrlPkg::clsBeq || cls == ctrlPkg::clsBne) ? 1 : 0);
        checkEq("epcWrite cycles", epcWrites, trap ? 1 : 0);
        checkEq("exception jump cycles", excJumps, trap ? 1 : 0);
        if (trap) checkEq("exception jump after epcWrite", excCycle > epcCycle, 1);
        checkEq("multInit cycles", multInits, (cls == ctrlPkg::clsMult) ? 1 : 0);
        checkEq("hiLoWrite cycles", hiLoWrites, (cls == ctrlPkg::clsMult) ? 1 : 0);
        if (cls == ctrlPkg::clsMult) begin
            checkEq("hiLoWrite delay", hiLoCycle - multCycle, `MULT_CYCLES + 1);
        end
    endtask

    task automatic classSweep();
        for (int i = 0; i <= int'(ctrlPkg::clsJr); i++) begin
            runInstr(ctrlPkg::instrClass_t'(i), 1'b0);
        end
    endtask

    task automatic randomMix();
        ctrlPkg::instrClass_t pool [10];
        pool = '{ctrlPkg::clsAdd, ctrlPkg::clsAddi, ctrlPkg::clsAddiu, ctrlPkg::clsLw,
                 ctrlPkg::clsSw, ctrlPkg::clsBeq, ctrlPkg::clsBne, ctrlPkg::clsJ,
                 ctrlPkg::clsJal, ctrlPkg::clsJr};
        repeat (40) begin
            runInstr(pool[$urandom_range(9, 0)], 1'b0);
        end
    endtask

    task automatic exceptionTest();
        runInstr(ctrlPkg::clsAdd, 1'b1);
        runInstr(ctrlPkg::clsAddi, 1'b1);
        runInstr(ctrlPkg::clsAddiu, 1'b1); // unsigned add never traps
        runInstr(ctrlPkg::clsBad, 1'b0);
        runInstr(ctrlPkg::clsAdd, 1'b0);
    endtask

    task automatic multiplyTest();
        runInstr(ctrlPkg::clsMult, 1'b0);
        runInstr(ctrlPkg::clsJ, 1'b0);
        runInstr(ctrlPkg::clsMult, 1'b0);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        opcode = '0;
        funct = '0;
        overflow = 1'b0;
        errors = 0;
        timedOut = 1'b0;
        void'($urandom(32'h9e045f0e));
        fillLengths();
        resetTest();
        classSweep();
        randomMix();
        exceptionTest();
        multiplyTest();
        $display("run complete, %0d error(s)", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: logic/mipsControl.sv
module mipsControl (
    input  logic               clk,
    input  logic               reset,
    input  logic [5:0]         opcode,
    input  logic [5:0]         funct,
    input  logic               overflow,
    output ctrlPkg::ctrlWord_t ctrl
);

    ctrlPkg::instrClass_t cls;
    ctrlPkg::ctrlState_t  state;

    instrDecoder decoder (
        .opcode (opcode),
        .funct  (funct),
        .cls    (cls)
    );

    stateSequencer sequencer (
        .clk      (clk),
        .reset    (reset),
        .cls      (cls),
        .overflow (overflow),
        .state    (state)
    );

    // Moore outputs, decoded from state alone
    controlWordRom ctrlRom (
        .state (state),
        .ctrl  (ctrl)
    );

endmodule

// File: logic/controlWordRom.sv
`include "ctrl_consts.svh"

module controlWordRom (
    input  ctrlPkg::ctrlState_t state,
    output ctrlPkg::ctrlWord_t  ctrl
);

    always_comb begin
        ctrl = '0;
        case (state)
            ctrlPkg::stInit: begin // load sp with its reset value
                ctrl.reg_.regWrite = 1'b1;
                ctrl.reg_.regDst   = `DST_SP;
                ctrl.reg_.memToReg = `WB_SPINIT;
            end
            ctrlPkg::stFetch: begin // pc <= pc + 4
                ctrl.pc.pcWrite    = 1'b1;
                ctrl.pc.pcSrc      = `PCSRC_ALU;
                ctrl.mem.iorD      = `IORD_PC;
                ctrl.alu.aluSrcB   = 2'd1;
                ctrl.alu.aluOp     = `ALU_ADD;
            end
            ctrlPkg::stFetchWait: begin
                ctrl = '0;
            end
            ctrlPkg::stIrLoad: begin
                ctrl.mem.irWrite = 1'b1;
            end
            ctrlPkg::stDecode: begin
                ctrl.reg_.regALoad   = 1'b1;
                ctrl.reg_.regBLoad   = 1'b1;
                ctrl.alu.aluSrcB     = 2'd3; // branch offset
                ctrl.alu.aluOp       = `ALU_ADD;
                ctrl.alu.aluOutWrite = 1'b1;
            end
            ctrlPkg::stAluRR: begin
                ctrl.alu.aluSrcA     = 1'b1;
                ctrl.alu.aluOp       = `ALU_ADD;
                ctrl.alu.aluOutWrite = 1'b1;
            end
            ctrlPkg::stAluImm, ctrlPkg::stAddr: begin
                ctrl.alu.aluSrcA     = 1'b1;
                ctrl.alu.aluSrcB     = 2'd2; // sign-extended imm
                ctrl.alu.aluOp       = `ALU_ADD;
                ctrl.alu.aluOutWrite = 1'b1;
            end
            ctrlPkg::stAddWb: begin
                ctrl.reg_.regWrite = 1'b1;
                ctrl.reg_.regDst   = `DST_RD;
                ctrl.reg_.memToReg = `WB_ALUOUT;
            end
            ctrlPkg::stAddiWb: begin
                ctrl.reg_.regWrite = 1'b1;
                ctrl.reg_.regDst   = `DST_RT;
                ctrl.reg_.memToReg = `WB_ALUOUT;
            end
            ctrlPkg::stSwWrite: begin
                ctrl.mem.iorD     = `IORD_ALUOUT;
                ctrl.mem.memWrite = 1'b1;
            end
            ctrlPkg::stMemRead: begin
                ctrl.mem.iorD = `IORD_ALUOUT; // memory latches the address here
            end
            ctrlPkg::stMdrLoad, ctrlPkg::stExcMdr: begin
                ctrl.mem.mdrLoad = 1'b1;
            end
            ctrlPkg::stLwWb: begin
                ctrl.reg_.regWrite = 1'b1;
                ctrl.reg_.regDst   = `DST_RT;
                ctrl.reg_.memToReg = `WB_MDR;
            end
            ctrlPkg::stBeq, ctrlPkg::stBne: begin
                ctrl.pc.pcWriteCond = 1'b1;
                ctrl.pc.pcSrc       = `PCSRC_OUT; // target from decode
                ctrl.pc.eqOrNe      = (state == ctrlPkg::stBeq) ? 2'b10 : 2'b01;
                ctrl.alu.aluSrcA    = 1'b1;
                ctrl.alu.aluOp      = `ALU_SUB;
            end
            ctrlPkg::stJalLink: begin
                ctrl.reg_.regWrite = 1'b1;
                ctrl.reg_.regDst   = `DST_RA;
                ctrl.reg_.memToReg = `WB_PC;
            end
            ctrlPkg::stJump: begin
                ctrl.pc.pcWrite = 1'b1;
                ctrl.pc.pcSrc   = `PCSRC_JUMP;
            end
            ctrlPkg::stJr: begin
                ctrl.pc.pcWrite  = 1'b1;
                ctrl.pc.pcSrc    = `PCSRC_ALU;
                ctrl.alu.aluSrcA = 1'b1;
                ctrl.alu.aluOp   = `ALU_LOAD; // rs straight through
            end
            // epc gets pc - 4, handler address read from the vector slot
            ctrlPkg::stOvf, ctrlPkg::stBadOp: begin
                ctrl.mult.epcWrite = 1'b1;
                ctrl.mem.iorD      = (state == ctrlPkg::stOvf) ? `IORD_OVF : `IORD_BADOP;
                ctrl.alu.aluSrcB   = 2'd1;
                ctrl.alu.aluOp     = `ALU_SUB;
            end
            ctrlPkg::stExcJump: begin
                ctrl.pc.pcWrite = 1'b1;
                ctrl.pc.pcSrc   = `PCSRC_EXC;
            end
            ctrlPkg::stMultStart: begin
                ctrl.mult.multInit = 1'b1;
            end
            ctrlPkg::stMultDone: begin
                ctrl.mult.hiLoSrc   = 1'b1; // product into hi/lo
                ctrl.mult.hiLoWrite = 1'b1;
            end
            default: begin
                ctrl = '0; // waits and unused encodings
            end
        endcase
    end

endmodule

// File: logic/stateSequencer.sv
`include "ctrl_consts.svh"

module stateSequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  ctrlPkg::instrClass_t cls,
    input  logic                 overflow,
    output ctrlPkg::ctrlState_t  state
);

    ctrlPkg::ctrlState_t nextState;
    logic [5:0]          mulCount;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ctrlPkg::stInit;
            mulCount <= '0;
        end else begin
            state <= nextState;
            if (state == ctrlPkg::stMultStart) begin
                mulCount <= 6'(`MULT_CYCLES - 1);
            end else if (mulCount != '0) begin
                mulCount <= mulCount - 6'd1;
            end
        end
    end

    always_comb begin
        nextState = ctrlPkg::stFetch; // most execute states end here
        case (state)
            ctrlPkg::stInit:      nextState = ctrlPkg::stFetch;
            ctrlPkg::stFetch:     nextState = ctrlPkg::stFetchWait;
            ctrlPkg::stFetchWait: nextState = ctrlPkg::stIrLoad;
            ctrlPkg::stIrLoad:    nextState = ctrlPkg::stDecode;
            ctrlPkg::stDecode: begin
                case (cls)
                    ctrlPkg::clsAdd:   nextState = ctrlPkg::stAluRR;
                    ctrlPkg::clsAddi:  nextState = ctrlPkg::stAluImm;
                    ctrlPkg::clsAddiu: nextState = ctrlPkg::stAluImm;
                    ctrlPkg::clsLw:    nextState = ctrlPkg::stAddr;
                    ctrlPkg::clsSw:    nextState = ctrlPkg::stAddr;
                    ctrlPkg::clsBeq:   nextState = ctrlPkg::stBeq;
                    ctrlPkg::clsBne:   nextState = ctrlPkg::stBne;
                    ctrlPkg::clsJ:     nextState = ctrlPkg::stJump;
                    ctrlPkg::clsJal:   nextState = ctrlPkg::stJalLink;
                    ctrlPkg::clsJr:    nextState = ctrlPkg::stJr;
                    ctrlPkg::clsMult:  nextState = ctrlPkg::stMultStart;
                    default:           nextState = ctrlPkg::stBadOp;
                endcase
            end
            // overflow is valid while the ALU state computes the sum
            ctrlPkg::stAluRR: begin
                nextState = overflow ? ctrlPkg::stOvf : ctrlPkg::stAddWb;
            end
            ctrlPkg::stAluImm: begin
                if (cls == ctrlPkg::clsAddiu) begin
                    nextState = ctrlPkg::stAddiWb; // unsigned add never traps
                end else if (overflow) begin
                    nextState = ctrlPkg::stOvf;
                end else begin
                    nextState = ctrlPkg::stAddiWb;
                end
            end
            ctrlPkg::stAddr: begin
                if (cls == ctrlPkg::clsSw) begin
                    nextState = ctrlPkg::stSwWrite;
                end else begin
                    nextState = ctrlPkg::stMemRead;
                end
            end
            ctrlPkg::stMemRead:   nextState = ctrlPkg::stMemWait;
            ctrlPkg::stMemWait:   nextState = ctrlPkg::stMdrLoad;
            ctrlPkg::stMdrLoad:   nextState = ctrlPkg::stLwWb;
            ctrlPkg::stJalLink:   nextState = ctrlPkg::stJump;
            ctrlPkg::stOvf:       nextState = ctrlPkg::stExcWait;
            ctrlPkg::stBadOp:     nextState = ctrlPkg::stExcWait;
            ctrlPkg::stExcWait:   nextState = ctrlPkg::stExcMdr;
            ctrlPkg::stExcMdr:    nextState = ctrlPkg::stExcJump;
            ctrlPkg::stMultStart: nextState = ctrlPkg::stMultWait;
            ctrlPkg::stMultWait: begin
                if (mulCount == '0) begin
                    nextState = ctrlPkg::stMultDone;
                end else begin
                    nextState = ctrlPkg::stMultWait;
                end
            end
            default: nextState = ctrlPkg::stFetch;
        endcase
    end

    // counter only runs while waiting on the multiplier
    assert property (@(posedge clk) disable iff (reset)
        (mulCount != '0) |-> (state == ctrlPkg::stMultWait));

    // stInit lasts one cycle past reset and nothing else reaches it
    assert property (@(posedge clk) disable iff (reset)
        (state == ctrlPkg::stInit) |-> $past(reset));

    // ir only loads two cycles after the fetch read
    assert property (@(posedge clk) disable iff (reset)
        (state == ctrlPkg::stIrLoad) |-> ($past(state) == ctrlPkg::stFetchWait));

endmodule

// File: logic/instrDecoder.sv
`include "ctrl_consts.svh"

module instrDecoder (
    input  logic [5:0]          opcode,
    input  logic [5:0]          funct,
    output ctrlPkg::instrClass_t cls
);

    always_comb begin
        case (opcode)
            `OP_RTYPE: begin
                case (funct)
                    `FN_ADD:  cls = ctrlPkg::clsAdd;
                    `FN_JR:   cls = ctrlPkg::clsJr;
                    `FN_MULT: cls = ctrlPkg::clsMult;
                    default:  cls = ctrlPkg::clsBad; // unsupported funct
                endcase
            end
            `OP_ADDI: begin
                cls = ctrlPkg::clsAddi;
            end
            `OP_ADDIU: begin
                cls = ctrlPkg::clsAddiu;
            end
            `OP_LW: begin
                cls = ctrlPkg::clsLw;
            end
            `OP_SW: begin
                cls = ctrlPkg::clsSw;
            end
            `OP_BEQ: begin
                cls = ctrlPkg::clsBeq;
            end
            `OP_BNE: begin
                cls = ctrlPkg::clsBne;
            end
            `OP_J: begin
                cls = ctrlPkg::clsJ;
            end
            `OP_JAL: begin
                cls = ctrlPkg::clsJal;
            end
            default: begin
                cls = ctrlPkg::clsBad;
            end
        endcase
    end

endmodule

// File: logic/ctrlPkg.sv
package ctrlPkg;

    typedef enum logic [3:0] {
        clsAdd,
        clsAddi,
        clsAddiu,
        clsLw,
        clsSw,
        clsBeq,
        clsBne,
        clsJ,
        clsJal,
        clsJr,
        clsMult,
        clsBad
    } instrClass_t;

    typedef enum logic [4:0] {
        stInit,
        stFetch,
        stFetchWait,
        stIrLoad,
        stDecode,
        stAluRR,
        stAddWb,
        stAluImm,
        stAddiWb,
        stAddr,
        stSwWrite,
        stMemRead,
        stMemWait,
        stMdrLoad,
        stLwWb,
        stBeq,
        stBne,
        stJalLink,
        stJump,
        stJr,
        stOvf,
        stBadOp,
        stExcWait,
        stExcMdr,
        stExcJump,
        stMultStart,
        stMultWait,
        stMultDone
    } ctrlState_t;

    typedef struct packed {
        logic       pcWrite;
        logic       pcWriteCond;
        logic [2:0] pcSrc;
        logic [1:0] eqOrNe; // 2'b10 eq, 2'b01 ne
    } pcCtrl_t;

    typedef struct packed {
        logic [2:0] iorD;
        logic       memWrite;
        logic       irWrite;
        logic       mdrLoad;
    } memCtrl_t;

    typedef struct packed {
        logic       aluSrcA;     // 0 pc, 1 reg A
        logic [1:0] aluSrcB;     // reg B, 4, imm, imm<<2
        logic [2:0] aluOp;
        logic       aluOutSrc;
        logic       aluOutWrite;
    } aluCtrl_t;

    typedef struct packed {
        logic       regWrite;
        logic [1:0] regDst;
        logic [3:0] memToReg;
        logic       regALoad;
        logic       regBLoad;
    } regCtrl_t;

    typedef struct packed {
        logic multInit;
        logic hiLoSrc;
        logic hiLoWrite;
        logic epcWrite;
    } multCtrl_t;

    typedef struct packed {
        pcCtrl_t   pc;
        memCtrl_t  mem;
        aluCtrl_t  alu;
        regCtrl_t  reg_;
        multCtrl_t mult;
    } ctrlWord_t;

endpackage

// File: logic/ctrl_consts.svh
`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

// opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_JAL   6'h03
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDI  6'h08
`define OP_ADDIU 6'h09
`define OP_LW    6'h23
`define OP_SW    6'h2b

// R-type funct codes
`define FN_JR    6'h08
`define FN_MULT  6'h18
`define FN_ADD   6'h20

`define MULT_CYCLES 33 // multiplier latency

`define ALU_LOAD 3'd0 // passes A through
`define ALU_ADD  3'd1
`define ALU_SUB  3'd2

`define PCSRC_ALU  3'd0
`define PCSRC_OUT  3'd1
`define PCSRC_JUMP 3'd2
`define PCSRC_EXC  3'd3 // handler address from MDR

`define IORD_PC     3'd0
`define IORD_ALUOUT 3'd1
`define IORD_BADOP  3'd2 // invalid-opcode vector slot
`define IORD_OVF    3'd3 // overflow vector slot

`define DST_RT 2'd0
`define DST_RD 2'd1
`define DST_RA 2'd2
`define DST_SP 2'd3

`define WB_ALUOUT 4'd0
`define WB_MDR    4'd1
`define WB_PC     4'd6
`define WB_SPINIT 4'd7 // reset value of the stack pointer

`endif
